/* rtl/cache_params.svh */
// cache geometry macros for the two-way L1 cache

`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// byte offset within a 32-byte line
`define CACHE_S_OFFSET 5

// set index width
`define CACHE_S_INDEX 3

// tag is what remains of a 32-bit address
`define CACHE_S_TAG (32 - `CACHE_S_OFFSET - `CACHE_S_INDEX)

`define CACHE_S_MASK (2 ** `CACHE_S_OFFSET)
`define CACHE_S_LINE (8 * `CACHE_S_MASK)
`define CACHE_NUM_SETS (2 ** `CACHE_S_INDEX)

// value of valid, dirty and lru bits out of reset
`define CACHE_RESET_INVALID 1'b0

`endif

/* rtl/rv32i_types.sv */
// rv32i cache types for words, lines, masks and the control and status structs

`include "cache_params.svh"

package rv32i_types;

    typedef logic [31:0] rv32i_word;
    typedef logic [`CACHE_S_LINE-1:0] line_t;
    typedef logic [`CACHE_S_MASK-1:0] line_mask_t;
    typedef logic [`CACHE_S_TAG-1:0] tag_t;
    typedef logic [$clog2(`CACHE_NUM_SETS)-1:0] set_idx_t;

    // commands from control to datapath
    typedef struct packed {
        logic set_dirty;   // cpu write hit
        logic reset_dirty; // victim clean after fill
        logic set_valid;   // victim way
        logic load_tag;    // victim way
        logic load_data;   // fill victim from pmem
        logic set_lru;     // record hit way
        logic addr_sel;    // 1 = write-back address
    } cache_ctrl_t;

    // datapath flags back to control
    typedef struct packed {
        logic hit;
        logic victim_dirty;
    } cache_status_t;

endpackage : rv32i_types

/* rtl/array.sv */
// per-set register file with async read, payload type set per instance
`timescale 1ns/1ps
`include "cache_params.svh"

module array
    import rv32i_types::*;
#(
    parameter type width_t = logic,
    parameter int s_index = `CACHE_S_INDEX
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     load,
    input  set_idx_t rindex,
    input  set_idx_t windex,
    input  width_t   datain,
    output width_t   dataout
);

    width_t data [2**s_index];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 2**s_index; i++)
            begin
                data[i] <= {$bits(width_t){`CACHE_RESET_INVALID}};
            end
        end
        else if (load)
        begin
            data[windex] <= datain;
        end
    end

    assign dataout = data[rindex]; // combinational read

endmodule : array

/* rtl/data_array.sv */
// line storage per set with one write enable per byte
`timescale 1ns/1ps
`include "cache_params.svh"

module data_array
    import rv32i_types::*;
#(
    parameter int s_index = `CACHE_S_INDEX
)
(
    input  logic       clk,
    input  logic       reset,
    input  line_mask_t write_en,
    input  set_idx_t   index,
    input  line_t      datain,
    output line_t      dataout
);

    line_t data [2**s_index];

    // one byte lane per enable bit
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < $bits(line_mask_t); i++)
            begin
                if (write_en[i])
                begin
                    data[index][8*i +: 8] <= datain[8*i +: 8];
                end
            end
        end
    end

    assign dataout = data[index];

endmodule : data_array

/* rtl/cache_datapath.sv */
// two-way cache datapath with tag and state arrays, hit logic, line merge and pmem address
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_datapath
    import rv32i_types::*;
#(
    parameter int s_offset = `CACHE_S_OFFSET,
    parameter int s_index  = `CACHE_S_INDEX
)
(
    input  logic          clk,
    input  logic          reset,
    input  rv32i_word     mem_address,
    input  cache_ctrl_t   ctrl,
    input  line_mask_t    mem_byte_enable256,
    input  line_t         mem_wdata256,
    input  line_t         pmem_rdata,
    output cache_status_t status,
    output line_t         mem_rdata256,
    output line_t         pmem_wdata,
    output rv32i_word     pmem_address
);

    tag_t       set_tag;
    set_idx_t   set_idx;
    tag_t       tag0, tag1;
    logic       valid0, valid1;
    logic       dirty0, dirty1;
    logic       hit0, hit1;
    logic       lru;
    logic       victim;
    logic       read_way;
    line_t      line0, line1;
    line_t      line_in;
    line_mask_t we0, we1;

    assign set_tag = mem_address[31 -: $bits(tag_t)];
    assign set_idx = mem_address[s_offset +: s_index];

    assign hit0 = valid0 && (tag0 == set_tag);
    assign hit1 = valid1 && (tag1 == set_tag);
    assign victim = lru; // lru names the way to replace

    assign status.hit = hit0 || hit1;
    assign status.victim_dirty = victim ? dirty1 : dirty0;

    // fill wins over a byte merge into the hit way
    always_comb
    begin
        we0 = '0;
        we1 = '0;
        if (ctrl.load_data)
        begin
            if (victim)
                we1 = '1;
            else
                we0 = '1;
        end
        else if (ctrl.set_dirty)
        begin
            if (hit1)
                we1 = mem_byte_enable256;
            else if (hit0)
                we0 = mem_byte_enable256;
        end
    end

    assign line_in = ctrl.load_data ? pmem_rdata : mem_wdata256;

    assign read_way = status.hit ? hit1 : victim;
    assign mem_rdata256 = read_way ? line1 : line0;
    assign pmem_wdata = mem_rdata256;

    assign pmem_address = ctrl.addr_sel ?
        {(victim ? tag1 : tag0), set_idx, {s_offset{1'b0}}} :
        {mem_address[31:s_offset], {s_offset{1'b0}}};

    array #(.width_t(tag_t), .s_index(s_index)) tag_array_0 (
        .clk(clk), .reset(reset), .load(ctrl.load_tag && !victim),
        .rindex(set_idx), .windex(set_idx), .datain(set_tag), .dataout(tag0)
    );

    array #(.width_t(tag_t), .s_index(s_index)) tag_array_1 (
        .clk(clk), .reset(reset), .load(ctrl.load_tag && victim),
        .rindex(set_idx), .windex(set_idx), .datain(set_tag), .dataout(tag1)
    );

    array #(.width_t(logic), .s_index(s_index)) valid_array_0 (
        .clk(clk), .reset(reset), .load(ctrl.set_valid && !victim),
        .rindex(set_idx), .windex(set_idx), .datain(1'b1), .dataout(valid0)
    );

    array #(.width_t(logic), .s_index(s_index)) valid_array_1 (
        .clk(clk), .reset(reset), .load(ctrl.set_valid && victim),
        .rindex(set_idx), .windex(set_idx), .datain(1'b1), .dataout(valid1)
    );

    // set on write hit and cleared on the victim after fill
    array #(.width_t(logic), .s_index(s_index)) dirty_array_0 (
        .clk(clk), .reset(reset),
        .load((ctrl.set_dirty && hit0) || (ctrl.reset_dirty && !victim)),
        .rindex(set_idx), .windex(set_idx), .datain(ctrl.set_dirty), .dataout(dirty0)
    );

    array #(.width_t(logic), .s_index(s_index)) dirty_array_1 (
        .clk(clk), .reset(reset),
        .load((ctrl.set_dirty && hit1) || (ctrl.reset_dirty && victim)),
        .rindex(set_idx), .windex(set_idx), .datain(ctrl.set_dirty), .dataout(dirty1)
    );

    array #(.width_t(logic), .s_index(s_index)) lru_array (
        .clk(clk), .reset(reset), .load(ctrl.set_lru),
        .rindex(set_idx), .windex(set_idx), .datain(!hit1), .dataout(lru) // other way
    );

    data_array #(.s_index(s_index)) line_array_0 (
        .clk(clk), .reset(reset), .write_en(we0),
        .index(set_idx), .datain(line_in), .dataout(line0)
    );

    data_array #(.s_index(s_index)) line_array_1 (
        .clk(clk), .reset(reset), .write_en(we1),
        .index(set_idx), .datain(line_in), .dataout(line1)
    );

endmodule : cache_datapath

/* rtl/cache_control.sv */
// cache control FSM sequencing hit, write-back and allocate
`timescale 1ns/1ps

module cache_control
    import rv32i_types::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          mem_read,
    input  logic          mem_write,
    input  cache_status_t status,
    input  logic          pmem_resp,
    output cache_ctrl_t   ctrl,
    output logic          mem_resp,
    output logic          pmem_read,
    output logic          pmem_write
);

    typedef enum logic [1:0] {
        idle,
        compare,
        writeback,
        allocate
    } state_t;

    state_t state, next_state;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= idle;
        else
            state <= next_state;
    end

    // next state
    always_comb
    begin
        next_state = state;
        unique case (state)
            idle:
            begin
                if (mem_read || mem_write)
                    next_state = compare;
            end
            compare:
            begin
                if (status.hit)
                    next_state = idle;
                else if (status.victim_dirty)
                    next_state = writeback;
                else
                    next_state = allocate;
            end
            writeback:
            begin
                if (pmem_resp)
                    next_state = allocate;
            end
            allocate:
            begin
                if (pmem_resp)
                    next_state = compare; // retry, now a hit
            end
        endcase
    end

    // outputs
    always_comb
    begin
        ctrl = '0;
        mem_resp = 1'b0;
        pmem_read = 1'b0;
        pmem_write = 1'b0;
        unique case (state)
            idle:
            begin
                ctrl = '0;
            end
            compare:
            begin
                if (status.hit)
                begin
                    mem_resp = 1'b1;
                    ctrl.set_lru = 1'b1;
                    ctrl.set_dirty = mem_write; // merge on write hit
                end
            end
            writeback:
            begin
                pmem_write = 1'b1;
                ctrl.addr_sel = 1'b1; // victim line address
            end
            allocate:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    ctrl.load_data = 1'b1;
                    ctrl.load_tag = 1'b1;
                    ctrl.set_valid = 1'b1;
                    ctrl.reset_dirty = 1'b1;
                end
            end
        endcase
    end

endmodule : cache_control

/* rtl/bus_adapter.sv */
// bus adapter between 32-bit cpu words and 256-bit cache lines
`timescale 1ns/1ps

module bus_adapter
    import rv32i_types::*;
(
    input  rv32i_word  address,
    input  rv32i_word  mem_wdata,
    input  logic [3:0] mem_byte_enable,
    input  line_t      mem_rdata256,
    output line_t      mem_wdata256,
    output line_mask_t mem_byte_enable256,
    output rv32i_word  mem_rdata
);

    logic [2:0] word_sel;

    assign word_sel = address[4:2]; // word slot within the line

    // same word in every slot, enables pick the one that lands
    assign mem_wdata256 = {($bits(line_t) / 32){mem_wdata}};

    assign mem_byte_enable256 = line_mask_t'(mem_byte_enable) << {word_sel, 2'b00};

    assign mem_rdata = mem_rdata256[{word_sel, 5'b00000} +: 32];

endmodule : bus_adapter

/* rtl/cache.sv */
// L1 cache top wiring control, datapath and bus adapter between cpu and pmem
`timescale 1ns/1ps
`include "cache_params.svh"

module cache
    import rv32i_types::*;
(
    input  logic       clk,
    input  logic       reset,

    // cpu side
    input  rv32i_word  mem_address,
    input  logic       mem_read,
    input  logic       mem_write,
    input  logic [3:0] mem_byte_enable,
    input  rv32i_word  mem_wdata,
    output rv32i_word  mem_rdata,
    output logic       mem_resp,

    // physical memory side
    output logic       pmem_read,
    output logic       pmem_write,
    output rv32i_word  pmem_address,
    output line_t      pmem_wdata,
    input  line_t      pmem_rdata,
    input  logic       pmem_resp
);

    cache_ctrl_t   ctrl;
    cache_status_t status;
    line_t         mem_wdata256;
    line_t         mem_rdata256;
    line_mask_t    mem_byte_enable256;

    cache_control control (
        .clk(clk),
        .reset(reset),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .status(status),
        .pmem_resp(pmem_resp),
        .ctrl(ctrl),
        .mem_resp(mem_resp),
        .pmem_read(pmem_read),
        .pmem_write(pmem_write)
    );

    cache_datapath #(.s_offset(`CACHE_S_OFFSET), .s_index(`CACHE_S_INDEX)) datapath (
        .clk(clk),
        .reset(reset),
        .mem_address(mem_address),
        .ctrl(ctrl),
        .mem_byte_enable256(mem_byte_enable256),
        .mem_wdata256(mem_wdata256),
        .pmem_rdata(pmem_rdata),
        .status(status),
        .mem_rdata256(mem_rdata256),
        .pmem_wdata(pmem_wdata),
        .pmem_address(pmem_address)
    );

    bus_adapter adapter (
        .address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_byte_enable(mem_byte_enable),
        .mem_rdata256(mem_rdata256),
        .mem_wdata256(mem_wdata256),
        .mem_byte_enable256(mem_byte_enable256),
        .mem_rdata(mem_rdata)
    );

endmodule : cache

/* tb/pmem_model.sv */
// physical memory model with a random line image, fixed-latency responses and access counters
`timescale 1ns/1ps

module pmem_model
    import rv32i_types::*;
#(
    parameter int latency = 4,
    parameter int num_lines = 64,
    parameter int seed_init = 31
)
(
    input  logic      clk,
    input  logic      reset,
    input  logic      pmem_read,
    input  logic      pmem_write,
    input  rv32i_word pmem_address,
    input  line_t     pmem_wdata,
    output line_t     pmem_rdata,
    output logic      pmem_resp
);

    localparam int idx_w = $clog2(num_lines);

    line_t     mem [num_lines];
    int        wait_cnt;
    int        read_count;
    int        write_count;
    rv32i_word last_write_addr;
    line_t     last_write_line;
    integer    seed;

    // same generation order as the testbench image
    initial
    begin
        seed = seed_init;
        for (int i = 0; i < num_lines; i++)
        begin
            for (int j = 0; j < 8; j++)
            begin
                mem[i][32*j +: 32] = $random(seed);
            end
        end
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            pmem_resp <= 1'b0;
            wait_cnt <= 0;
            read_count <= 0;
            write_count <= 0;
        end
        else if (pmem_resp)
        begin
            pmem_resp <= 1'b0; // one-cycle pulse
            wait_cnt <= 0;
        end
        else if (pmem_read || pmem_write)
        begin
            if (wait_cnt == latency - 1)
            begin
                pmem_resp <= 1'b1;
                if (pmem_write)
                begin
                    mem[pmem_address[5 +: idx_w]] <= pmem_wdata;
                    write_count <= write_count + 1;
                    last_write_addr <= pmem_address;
                    last_write_line <= pmem_wdata;
                end
                else
                begin
                    pmem_rdata <= mem[pmem_address[5 +: idx_w]]; // valid with resp
                    read_count <= read_count + 1;
                end
            end
            else
            begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule : pmem_model

/* tb/cache_tb.sv */
// testbench for the two-way L1 cache with a reference memory image
`timescale 1ns/1ps

module cache_tb
    import rv32i_types::*;
();

    localparam int timeout_cycles = 3000;

    logic       clk = 1'b0;
    logic       reset;
    rv32i_word  mem_address;
    logic       mem_read;
    logic       mem_write;
    logic [3:0] mem_byte_enable;
    rv32i_word  mem_wdata;
    rv32i_word  mem_rdata;
    logic       mem_resp;
    logic       pmem_read;
    logic       pmem_write;
    rv32i_word  pmem_address;
    line_t      pmem_wdata;
    line_t      pmem_rdata;
    logic       pmem_resp;

    line_t  ref_mem [64];
    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycle_count = 0;

    cache uut (.*);

    pmem_model #(.latency(4), .num_lines(64), .seed_init(31)) pmem (
        .clk(clk), .reset(reset), .pmem_read(pmem_read), .pmem_write(pmem_write),
        .pmem_address(pmem_address), .pmem_wdata(pmem_wdata),
        .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [255:0] actual,
                               input logic [255:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, actual,
                     expected);
        end
    endtask

    function automatic rv32i_word ref_word(input rv32i_word addr);
        return ref_mem[addr[10:5]][32*addr[4:2] +: 32];
    endfunction

    // hold the request until mem_resp and release it after the edge
    task automatic cpu_access(input logic write, input rv32i_word addr, input rv32i_word data,
                              input logic [3:0] mask, output rv32i_word rdata,
                              output int cycles);
        mem_address = addr;
        mem_read = !write;
        mem_write = write;
        mem_byte_enable = mask;
        mem_wdata = data;
        cycles = 0;
        @(negedge clk);
        while (!mem_resp)
        begin
            cycles++;
            @(negedge clk);
        end
        rdata = mem_rdata;
        @(posedge clk);
        #2;
        mem_read = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic cpu_read(input rv32i_word addr, output int cycles);
        rv32i_word rdata;
        cpu_access(1'b0, addr, 32'h0, 4'h0, rdata, cycles);
        check_value("mem_rdata", rdata, ref_word(addr));
    endtask

    task automatic cpu_write(input rv32i_word addr, input rv32i_word data, input logic [3:0] mask);
        rv32i_word rdata;
        int cycles;
        cpu_access(1'b1, addr, data, mask, rdata, cycles);
        for (int b = 0; b < 4; b++)
        begin
            if (mask[b])
                ref_mem[addr[10:5]][32*addr[4:2] + 8*b +: 8] = data[8*b +: 8];
        end
    endtask

    task automatic reset_and_first_miss();
        int reads_before;
        int cycles;
        check_value("mem_resp", mem_resp, 0);
        check_value("pmem_read", pmem_read, 0);
        check_value("pmem_write", pmem_write, 0);
        reads_before = pmem.read_count;
        cpu_read(32'h0000_0040, cycles);
        check_value("pmem read count", pmem.read_count - reads_before, 1);
        check_value("pmem write count", pmem.write_count, 0);
    endtask

    task automatic repeated_read_hits();
        int reads_before;
        int cycles;
        reads_before = pmem.read_count;
        cpu_read(32'h0000_0044, cycles);
        check_value("hit latency", cycles, 1);
        cpu_read(32'h0000_005c, cycles);
        check_value("hit latency", cycles, 1);
        check_value("pmem read count", pmem.read_count - reads_before, 0);
    endtask

    task automatic partial_write_merge();
        int accesses_before;
        int cycles;
        accesses_before = pmem.read_count + pmem.write_count;
        cpu_write(32'h0000_0048, 32'haabb_ccdd, 4'b0101);
        cpu_read(32'h0000_0048, cycles);
        cpu_write(32'h0000_0048, 32'h1122_3344, 4'b1000);
        cpu_read(32'h0000_0048, cycles);
        cpu_write(32'h0000_004c, 32'h5566_7788, 4'b0110);
        cpu_read(32'h0000_004c, cycles);
        check_value("pmem access count", pmem.read_count + pmem.write_count - accesses_before, 0);
    endtask

    // A and B share set 3 and C replaces B
    task automatic lru_replacement();
        int reads_before;
        int cycles;
        cpu_read(32'h0000_0060, cycles);
        cpu_read(32'h0000_0160, cycles);
        cpu_read(32'h0000_0064, cycles);
        cpu_read(32'h0000_0260, cycles);
        reads_before = pmem.read_count;
        cpu_read(32'h0000_0068, cycles);
        check_value("pmem read count after A", pmem.read_count - reads_before, 0);
        cpu_read(32'h0000_0164, cycles);
        check_value("pmem read count after B", pmem.read_count - reads_before, 1);
        check_value("pmem write count", pmem.write_count, 0);
    endtask

    task automatic dirty_eviction();
        int writes_before;
        int cycles;
        cpu_write(32'h0000_0084, 32'hdead_beef, 4'b1111);
        writes_before = pmem.write_count;
        cpu_read(32'h0000_0184, cycles);
        check_value("pmem write count", pmem.write_count - writes_before, 0);
        cpu_read(32'h0000_0288, cycles); // evicts the written line
        check_value("pmem write count", pmem.write_count - writes_before, 1);
        check_value("pmem_address", pmem.last_write_addr, 32'h0000_0080);
        check_value("pmem_wdata", pmem.last_write_line, ref_mem[4]);
        writes_before = pmem.write_count;
        cpu_read(32'h0000_038c, cycles); // clean victim
        check_value("pmem write count", pmem.write_count - writes_before, 0);
    endtask

    task automatic word_slot_access();
        int cycles;
        for (int slot = 0; slot < 8; slot++)
            cpu_read(32'h0000_00a0 + 4*slot, cycles);
        for (int slot = 0; slot < 8; slot++)
            cpu_write(32'h0000_00a0 + 4*slot, $random(seed), (slot % 2) ? 4'b1111 : 4'b0011);
        for (int slot = 0; slot < 8; slot++)
            cpu_read(32'h0000_00a0 + 4*slot, cycles);
    endtask

    initial
    begin
        reset = 1'b1;
        mem_address = '0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_byte_enable = 4'h0;
        mem_wdata = '0;
        seed = 31;
        for (int i = 0; i < 64; i++)
        begin
            for (int j = 0; j < 8; j++)
                ref_mem[i][32*j +: 32] = $random(seed);
        end
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        reset_and_first_miss();
        repeated_read_hits();
        partial_write_merge();
        lru_replacement();
        dirty_eviction();
        word_slot_access();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule : cache_tb

/* rv32i_l1_cache.f */
+incdir+rtl
rtl/rv32i_types.sv
rtl/array.sv
rtl/data_array.sv
rtl/cache_datapath.sv
rtl/cache_control.sv
rtl/bus_adapter.sv
rtl/cache.sv
tb/pmem_model.sv
tb/cache_tb.sv
